/* logic/control_params.svh */
// field widths and opcode/funct codes of the multicycle controller
// pulled in by the package, the decoder, the top level and the testbench
`ifndef CONTROL_PARAMS_SVH
`define CONTROL_PARAMS_SVH

`define OPCODE_W 6
`define FUNCT_W 6

// encoding widths of the controller enums
`define STATE_W 5
`define CLASS_W 5
`define ALUOP_W 3
`define SHIFTOP_W 3
`define DSRC_W 4

`define OP_RTYPE 6'h00
`define OP_ADDI 6'h08
`define OP_ADDIU 6'h09

// R-type funct codes
`define F_ADD 6'h20
`define F_SUB 6'h22
`define F_AND 6'h24
`define F_SLT 6'h2a
`define F_SLL 6'h00
`define F_SRL 6'h02
`define F_SRA 6'h03
`define F_SLLV 6'h04
`define F_SRAV 6'h07
`define F_MFHI 6'h10
`define F_MFLO 6'h12
`define F_JR 6'h08
`define F_BREAK 6'h0d

`endif

/* logic/controlPkg.sv */
// state, class and control-word types shared by the controller stages
`include "control_params.svh"

package controlPkg;

    typedef enum logic [`STATE_W-1:0] {
        FETCH, FETCH2, IR_WAIT, DECODE, DISPATCH,
        ALU_EXEC, ALU_WRITE,
        IMM_EXEC, IMM_WRITE,
        SHIFT_EXEC, SHIFT_WRITE,
        SLT_WRITE, MOVE_HI, MOVE_LO, JUMP_REG, BREAK_TRAP,
        NO_OPCODE, WAIT_FINAL
    } stateT;

    typedef enum logic [`CLASS_W-1:0] {
        CLS_ADD, CLS_SUB, CLS_AND, CLS_SLT,
        CLS_SLL, CLS_SRL, CLS_SRA, CLS_SLLV, CLS_SRAV,
        CLS_MFHI, CLS_MFLO, CLS_JR, CLS_BREAK,
        CLS_ADDI, CLS_ADDIU, CLS_ILLEGAL
    } instrClassT;

    typedef enum logic [`ALUOP_W-1:0] {
        ALU_PASS = 3'd0,
        ALU_ADD = 3'd1,
        ALU_SUB = 3'd2,
        ALU_AND = 3'd3,
        ALU_SLT = 3'd7
    } aluOpT;

    typedef enum logic [`SHIFTOP_W-1:0] {
        SH_NONE = 3'd0,
        SH_LEFT = 3'd2,
        SH_RIGHT_LOGIC = 3'd3,
        SH_RIGHT_ARITH = 3'd4
    } shiftOpT;

    typedef enum logic [`DSRC_W-1:0] {
        DS_ALU_OUT = 4'd0,
        DS_LO = 4'd2,
        DS_HI = 4'd3,
        DS_SHIFTER = 4'd4,
        DS_LESS = 4'd5,
        DS_RESET_SP = 4'd10 // stack pointer init value
    } dataSrcT;

    typedef struct packed {
        logic pcWrite;
        logic regWrite;
        logic aluOutWrite;
        logic irWrite;
        logic shiftSource;
        logic shiftAmountSource;
        logic regFileRead;
        logic aWrite;
        logic bWrite;
        logic epcWrite;
        logic [1:0] muxA;
        logic [1:0] muxB;
        logic [1:0] exceptCode;
        logic [1:0] regDest;
        shiftOpT shiftOp;
        aluOpT aluOp;
        dataSrcT dataSource;
    } controlWordT;

endpackage

/* logic/instrDecoder.sv */
// maps opcode and funct onto an instruction class, purely combinational
// anything outside the supported set decodes as illegal
`include "control_params.svh"

module instrDecoder (
    input logic [`OPCODE_W-1:0] opcode,
    input logic [`FUNCT_W-1:0] funct,
    output controlPkg::instrClassT instrClass
);
    import controlPkg::*;

    always_comb begin
        instrClass = CLS_ILLEGAL;
        case (opcode)
            `OP_RTYPE: begin
                case (funct)
                    `F_ADD: instrClass = CLS_ADD;
                    `F_SUB: instrClass = CLS_SUB;
                    `F_AND: instrClass = CLS_AND;
                    `F_SLT: instrClass = CLS_SLT;
                    `F_SLL: instrClass = CLS_SLL;
                    `F_SRL: instrClass = CLS_SRL;
                    `F_SRA: instrClass = CLS_SRA;
                    `F_SLLV: instrClass = CLS_SLLV;
                    `F_SRAV: instrClass = CLS_SRAV;
                    `F_MFHI: instrClass = CLS_MFHI;
                    `F_MFLO: instrClass = CLS_MFLO;
                    `F_JR: instrClass = CLS_JR;
                    `F_BREAK: instrClass = CLS_BREAK;
                    default: instrClass = CLS_ILLEGAL; // unused funct traps too
                endcase
            end
            `OP_ADDI: instrClass = CLS_ADDI;
            `OP_ADDIU: instrClass = CLS_ADDIU;
            default: instrClass = CLS_ILLEGAL;
        endcase
    end

    // a known opcode always lands on some class, even with a bad funct
    aClassKnown: assert final ($isunknown(opcode) || !$isunknown(instrClass))
        else $error("instrClass unknown for opcode %h", opcode);

endmodule

/* logic/stateSequencer.sv */
// state register and next-state logic of the multicycle controller
// every instruction runs the fetch chain, dispatches on its class, then waits once
module stateSequencer (
    input logic clk,
    input logic reset,
    input controlPkg::instrClassT instrClass,
    output controlPkg::stateT state
);
    import controlPkg::*;

    stateT nextState;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= FETCH;
        end else begin
            state <= nextState;
        end
    end

    always_comb begin
        nextState = FETCH;
        case (state)
            FETCH: nextState = FETCH2;
            FETCH2: nextState = IR_WAIT;
            IR_WAIT: nextState = DECODE;
            DECODE: nextState = DISPATCH;
            DISPATCH: begin
                case (instrClass)
                    CLS_ADD, CLS_SUB, CLS_AND: nextState = ALU_EXEC;
                    CLS_ADDI, CLS_ADDIU: nextState = IMM_EXEC;
                    CLS_SLL, CLS_SRL, CLS_SRA,
                    CLS_SLLV, CLS_SRAV: nextState = SHIFT_EXEC;
                    CLS_SLT: nextState = SLT_WRITE;
                    CLS_MFHI: nextState = MOVE_HI;
                    CLS_MFLO: nextState = MOVE_LO;
                    CLS_JR: nextState = JUMP_REG;
                    CLS_BREAK: nextState = BREAK_TRAP;
                    default: nextState = NO_OPCODE;
                endcase
            end
            ALU_EXEC: nextState = ALU_WRITE;
            IMM_EXEC: nextState = IMM_WRITE;
            SHIFT_EXEC: nextState = SHIFT_WRITE;
            // single-cycle and write states all drain through the wait
            ALU_WRITE, IMM_WRITE, SHIFT_WRITE,
            SLT_WRITE, MOVE_HI, MOVE_LO,
            JUMP_REG, BREAK_TRAP, NO_OPCODE: nextState = WAIT_FINAL;
            WAIT_FINAL: nextState = FETCH;
            default: nextState = FETCH; // recover from a stray encoding
        endcase
    end

    aStateLegal: assert property (@(posedge clk) disable iff (reset)
        !$isunknown(state) && (state inside {[FETCH:WAIT_FINAL]}))
        else $error("illegal controller state %0d", state);

endmodule

/* logic/controlWordGen.sv */
// registers the datapath control word for the current controller state
// output lags the state by one cycle; reset forces the stack pointer setup word
module controlWordGen (
    input logic clk,
    input logic reset,
    input controlPkg::stateT state,
    input controlPkg::instrClassT instrClass,
    output controlPkg::controlWordT ctrl
);
    import controlPkg::*;

    localparam controlWordT RESET_WORD = '{
        regWrite: 1'b1,
        regDest: 2'd3,
        shiftOp: SH_NONE,
        aluOp: ALU_PASS,
        dataSource: DS_RESET_SP,
        default: '0
    };

    instrClassT classHeld;
    controlWordT word;
    logic immShift;

    // class captured as the sequencer leaves DISPATCH
    always_ff @(posedge clk) begin
        if (state == DISPATCH) begin
            classHeld <= instrClass;
        end
    end

    // sll/srl/sra take the amount from shamt, the v forms from a register
    assign immShift = (classHeld == CLS_SLL) || (classHeld == CLS_SRL)
        || (classHeld == CLS_SRA);

    always_comb begin
        word = '0;
        case (state)
            FETCH: begin
                word.pcWrite = 1'b1;
                word.muxB = 2'd1; // pc + 4
                word.aluOp = ALU_ADD;
            end
            FETCH2: word.pcWrite = 1'b1;
            IR_WAIT: word.irWrite = 1'b1;
            DECODE: begin
                word.aluOutWrite = 1'b1; // speculative branch target
                word.regFileRead = 1'b1;
                word.aWrite = 1'b1;
                word.bWrite = 1'b1;
                word.muxB = 2'd3;
                word.aluOp = ALU_ADD;
            end
            ALU_EXEC: begin
                word.aluOutWrite = 1'b1;
                word.muxA = 2'd1;
                case (classHeld)
                    CLS_SUB: word.aluOp = ALU_SUB;
                    CLS_AND: word.aluOp = ALU_AND;
                    default: word.aluOp = ALU_ADD;
                endcase
            end
            IMM_EXEC: begin
                word.aluOutWrite = 1'b1;
                word.muxA = 2'd1;
                word.muxB = 2'd2; // sign-extended immediate
                word.aluOp = ALU_ADD;
            end
            SHIFT_EXEC: begin
                word.shiftSource = immShift;
                word.shiftAmountSource = immShift;
                case (classHeld)
                    CLS_SLL, CLS_SLLV: word.shiftOp = SH_LEFT;
                    CLS_SRL: word.shiftOp = SH_RIGHT_LOGIC;
                    default: word.shiftOp = SH_RIGHT_ARITH;
                endcase
            end
            ALU_WRITE, IMM_WRITE, SHIFT_WRITE, MOVE_HI, MOVE_LO: begin
                word.regWrite = 1'b1;
                word.regDest = (state == IMM_WRITE) ? 2'd0 : 2'd1; // rt vs rd
                case (state)
                    SHIFT_WRITE: word.dataSource = DS_SHIFTER;
                    MOVE_HI: word.dataSource = DS_HI;
                    MOVE_LO: word.dataSource = DS_LO;
                    default: word.dataSource = DS_ALU_OUT;
                endcase
            end
            SLT_WRITE: begin
                word.regWrite = 1'b1;
                word.regDest = 2'd1;
                word.muxA = 2'd1;
                word.aluOp = ALU_SLT;
                word.dataSource = DS_LESS;
            end
            JUMP_REG: begin
                word.pcWrite = 1'b1;
                word.muxA = 2'd1;
            end
            BREAK_TRAP: begin
                word.muxB = 2'd1;
                word.aluOp = ALU_SUB; // pc - 4
            end
            NO_OPCODE: begin
                word.epcWrite = 1'b1;
                word.exceptCode = 2'd1;
            end
            default: word = '0; // DISPATCH and WAIT_FINAL idle the datapath
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            ctrl <= RESET_WORD;
        end else begin
            ctrl <= word;
        end
    end

    aNoWriteClash: assert property (@(posedge clk) disable iff (reset)
        !(ctrl.regWrite && ctrl.aluOutWrite))
        else $error("regWrite and aluOutWrite both high");

endmodule

/* logic/controlUnit.sv */
// multicycle controller top: decoder, sequencer and control word register
// the registered word is fanned out to one port per datapath control
`include "control_params.svh"

module controlUnit (
    input logic clk,
    input logic reset,
    input logic [`OPCODE_W-1:0] opcode,
    input logic [`FUNCT_W-1:0] funct,
    output logic pcWrite,
    output logic regWrite,
    output logic aluOutWrite,
    output logic irWrite,
    output logic shiftSource,
    output logic shiftAmountSource,
    output logic regFileRead,
    output logic aWrite,
    output logic bWrite,
    output logic epcWrite,
    output logic [1:0] muxA,
    output logic [1:0] muxB,
    output logic [1:0] exceptCode,
    output logic [1:0] regDest,
    output controlPkg::shiftOpT shiftOp,
    output controlPkg::aluOpT aluOp,
    output controlPkg::dataSrcT dataSource
);
    import controlPkg::*;

    instrClassT instrClass;
    stateT state;
    controlWordT ctrl;

    instrDecoder decoder (
        .opcode(opcode),
        .funct(funct),
        .instrClass(instrClass)
    );

    stateSequencer sequencer (
        .clk(clk),
        .reset(reset),
        .instrClass(instrClass),
        .state(state)
    );

    controlWordGen wordGen (
        .clk(clk),
        .reset(reset),
        .state(state),
        .instrClass(instrClass),
        .ctrl(ctrl)
    );

    assign pcWrite = ctrl.pcWrite;
    assign regWrite = ctrl.regWrite;
    assign aluOutWrite = ctrl.aluOutWrite;
    assign irWrite = ctrl.irWrite;
    assign shiftSource = ctrl.shiftSource;
    assign shiftAmountSource = ctrl.shiftAmountSource;
    assign regFileRead = ctrl.regFileRead;
    assign aWrite = ctrl.aWrite;
    assign bWrite = ctrl.bWrite;
    assign epcWrite = ctrl.epcWrite;
    assign muxA = ctrl.muxA;
    assign muxB = ctrl.muxB;
    assign exceptCode = ctrl.exceptCode;
    assign regDest = ctrl.regDest;
    assign shiftOp = ctrl.shiftOp;
    assign aluOp = ctrl.aluOp;
    assign dataSource = ctrl.dataSource;

endmodule

/* tb/clockGen.sv */
// free-running 10 ns clock, reset held high for the first 10 rising edges
module clockGen (
    output logic clk,
    output logic reset
);
    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial begin
        reset = 1'b1;
        repeat (10) @(posedge clk);
        reset <= 1'b0; // released on the rising edge like any other input
    end

endmodule

/* tb/controlUnitTb.sv */
// testbench of the multicycle controller, replays instructions from tb/controlPatterns.txt
// and checks every control word and the spacing of the irWrite pulses
`include "control_params.svh"

module controlUnitTb;
    timeunit 1ns;
    timeprecision 100ps;
    import controlPkg::*;

    logic clk;
    logic reset;
    logic [`OPCODE_W-1:0] opcode;
    logic [`FUNCT_W-1:0] funct;
    controlWordT word; // dut outputs gathered back into one word
    controlWordT w;
    controlWordT prev1;
    controlWordT prev2;
    logic [$bits(controlWordT)-1:0] raw[6];
    logic [$bits(controlWordT)-1:0] pat[$]; // six entries per row, row 0 is fixed words
    logic [`OPCODE_W-1:0] op;
    string line;
    int fd;
    int count;
    int lastIr;
    int samples = 0;
    int cycles = 0;
    int cycleLimit;

    clockGen clocks (.clk(clk), .reset(reset));

    controlUnit dut (
        .clk(clk), .reset(reset), .opcode(opcode), .funct(funct),
        .pcWrite(word.pcWrite), .regWrite(word.regWrite), .aluOutWrite(word.aluOutWrite),
        .irWrite(word.irWrite), .shiftSource(word.shiftSource),
        .shiftAmountSource(word.shiftAmountSource), .regFileRead(word.regFileRead),
        .aWrite(word.aWrite), .bWrite(word.bWrite), .epcWrite(word.epcWrite),
        .muxA(word.muxA), .muxB(word.muxB), .exceptCode(word.exceptCode),
        .regDest(word.regDest), .shiftOp(word.shiftOp), .aluOp(word.aluOp),
        .dataSource(word.dataSource)
    );

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles > cycleLimit) begin
            $display("timeout: the run did not finish within %0d cycles", cycleLimit);
            $display("TEST FAILED");
            $fatal(1, "simulation timed out");
        end
    end

    task automatic sampleWord(output controlWordT got);
        @(negedge clk); // outputs settled mid-cycle
        samples++;
        got = word;
    endtask

    task automatic checkWord(input controlWordT got, input controlWordT exp, input string what);
        if (got !== exp) begin
            $display("** Error at %0t: %s word is %h, expected %h", $time, what, got, exp);
            $display("TEST FAILED");
            $fatal(1, "control word mismatch");
        end
    endtask

    task automatic checkLength(input int got, input int exp);
        if (got != exp) begin
            $display("** Error at %0t: instruction length %0d cycles, expected %0d",
                $time, got, exp);
            $display("TEST FAILED");
            $fatal(1, "instruction length mismatch");
        end
    endtask

    initial begin
        opcode = '0;
        funct = '0;
        void'($urandom(26));
        fd = $fopen("tb/controlPatterns.txt", "r");
        if (fd == 0) begin
            $display("cannot open tb/controlPatterns.txt, nothing to run");
            $display("TEST FAILED");
            $fatal(1, "pattern file missing");
        end
        while ($fgets(line, fd) > 0) begin
            // comment lines fail the scan and drop out here
            if ($sscanf(line, "%h %h %h %h %h %h", raw[0], raw[1], raw[2], raw[3], raw[4],
                    raw[5]) == 6) begin
                foreach (raw[k])
                    pat.push_back(raw[k]);
            end
        end
        $fclose(fd);
        count = pat.size() / 6 - 1;
        cycleLimit = 10 + 8 * count + 20;

        @(posedge clk);
        do begin
            sampleWord(w);
            checkWord(w, pat[0], "reset");
        end while (reset); // one more look in the cycle after release

        lastIr = 0;
        for (int i = 1; i <= count; i++) begin
            @(posedge clk);
            opcode <= pat[i*6][`OPCODE_W-1:0];
            funct <= pat[i*6+1][`FUNCT_W-1:0];
            if (pat[i*6+2][0]) begin
                op = `OPCODE_W'($urandom);
                while (op inside {`OP_RTYPE, `OP_ADDI, `OP_ADDIU})
                    op = `OPCODE_W'($urandom);
                opcode <= op;
            end
            sampleWord(w);
            while (!w.irWrite) begin // irWrite anchors each instruction
                prev2 = prev1;
                prev1 = w;
                sampleWord(w);
            end
            checkWord(prev2, pat[1], "FETCH");
            checkWord(prev1, pat[2], "FETCH2");
            checkWord(w, pat[3], "IR_WAIT");
            if (i > 1)
                checkLength(samples - lastIr, int'(pat[(i-1)*6+5]));
            lastIr = samples;
            sampleWord(w);
            checkWord(w, pat[4], "DECODE");
            sampleWord(w);
            checkWord(w, pat[5], "DISPATCH");
            sampleWord(w);
            checkWord(w, pat[i*6+3], "execute");
            if (pat[i*6+5] == 8) begin
                sampleWord(w);
                checkWord(w, pat[i*6+4], "write");
            end
            sampleWord(w);
            checkWord(w, pat[5], "WAIT_FINAL");
        end

        // the next fetch closes the length of the last instruction
        sampleWord(w);
        while (!w.irWrite)
            sampleWord(w);
        checkLength(samples - lastIr, int'(pat[count*6+5]));
        $display("TEST OK");
        $finish;
    end

endmodule

/* controlUnit.f */
+incdir+logic
logic/controlPkg.sv
logic/instrDecoder.sv
logic/stateSequencer.sv
logic/controlWordGen.sv
logic/controlUnit.sv
tb/clockGen.sv
tb/controlUnitTb.sv

/* tb/controlPatterns.txt */
# first row: reset, FETCH, FETCH2, IR_WAIT, DECODE and idle control words (28-bit hex)
# then: opcode funct randomOpcode execWord writeWord length, writeWord unused at length 7
4000c0a 8004010 8000000 1000000 238c010 0000000
00 20 0 2010010 4000400 8 add
00 22 0 2010020 4000400 8 sub
00 24 0 2010030 4000400 8 and
08 15 0 2018010 4000000 8 addi
09 3f 0 2018010 4000000 8 addiu
00 00 0 0c00100 4000404 8 sll
00 02 0 0c00180 4000404 8 srl
00 03 0 0c00200 4000404 8 sra
00 04 0 0000100 4000404 8 sllv
00 07 0 0000200 4000404 8 srav
00 2a 0 4010475 0000000 7 slt
00 10 0 4000403 0000000 7 mfhi
00 12 0 4000402 0000000 7 mflo
00 08 0 8010000 0000000 7 jr
00 0d 0 0004020 0000000 7 break
3f 00 1 0041000 0000000 7 random unused opcode
00 20 0 2010010 4000400 8 add after a trap
00 01 0 0041000 0000000 7 unused R-type funct
08 00 0 2018010 4000000 8 addi after a trap
3f 2a 1 0041000 0000000 7 random unused opcode
00 22 0 2010020 4000400 8 sub
